//--- Makefile
# Verilator flow for the address conflict manager.

VERILATOR ?= verilator
TOP       ?= tb_ccu_conflict_manager
FLIST     ?= ccu_conflict.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/ccu_conflict_chk.sv
`timescale 1ns/100ps
`default_nettype none

`include "ccu_settings.svh"

module ccu_conflict_chk import ccu_pkg::*; (
    input logic                            clk_i,
    input logic                            rst_ni,
    input logic       [`CCU_NUM_PORTS-1:0] resp_valid_i,
    input logic       [`CCU_NUM_PORTS-1:0] resp_ready_o,
    input resp_beat_t [`CCU_NUM_PORTS-1:0] resp_beat_i,
    input logic       [`CCU_NUM_PORTS-1:0] resp_valid_o,
    input logic       [`CCU_NUM_PORTS-1:0] resp_ready_i,
    input logic                            snoop_valid_i,
    input logic                            snoop_ready_o,
    input addr_t                           snoop_addr_i,
    input logic                            snoop_valid_o,
    input logic                            snoop_ready_i
);

    int unsigned fail_count = 0;  // read by the testbench at the end.

    for (genvar p = 0; p < `CCU_NUM_PORTS; p++) begin : gen_port
        resp_in_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
            resp_valid_i[p] && !resp_ready_o[p] |=> resp_valid_i[p] && $stable(resp_beat_i[p]))
        else begin
            $error("response input changed while it waited for ready");
            fail_count++;
        end

        resp_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
            resp_valid_o[p] && !resp_ready_i[p] |=> resp_valid_o[p])
        else begin
            $error("response output valid dropped before ready");
            fail_count++;
        end

        // a snoop and a response to the same line never leave together.
        same_line_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
            snoop_valid_o && resp_valid_o[p] |->
                snoop_addr_i[`CCU_LINE_BASE +: `CCU_LINE_WIDTH] !=
                resp_beat_i[p].addr[`CCU_LINE_BASE +: `CCU_LINE_WIDTH])
        else begin
            $error("snoop and response to one line were valid in the same cycle");
            fail_count++;
        end
    end

    snoop_in_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        snoop_valid_i && !snoop_ready_o |=> snoop_valid_i && $stable(snoop_addr_i))
    else begin
        $error("snoop input changed while it waited for ready");
        fail_count++;
    end

    reset_idle: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !snoop_valid_o && (resp_valid_o == '0))
    else begin
        $error("output valid raised right after reset");
        fail_count++;
    end

endmodule

bind ccu_conflict_manager ccu_conflict_chk i_conflict_chk (
    .clk_i,
    .rst_ni,
    .resp_valid_i,
    .resp_ready_o,
    .resp_beat_i,
    .resp_valid_o,
    .resp_ready_i,
    .snoop_valid_i,
    .snoop_ready_o,
    .snoop_addr_i,
    .snoop_valid_o,
    .snoop_ready_i
);

`default_nettype wire

//--- bench/tb_ccu_conflict_manager.sv
`timescale 1ns/100ps
`default_nettype none

`include "ccu_settings.svh"

module tb_ccu_conflict_manager import ccu_pkg::*; ();

    localparam int unsigned clk_period   = 40;
    localparam int unsigned reset_cycles = 16;
    localparam int unsigned wait_limit   = 100;  // cycles allowed for one handshake.
    localparam int unsigned num_tests    = 6;
    localparam int unsigned test_cycles  = 200;
    localparam longint unsigned watchdog_ns =
        2 * (reset_cycles + num_tests * test_cycles) * clk_period;

    logic                            clk_i;
    logic                            rst_ni;
    logic       [`CCU_NUM_PORTS-1:0] resp_valid_i;
    logic       [`CCU_NUM_PORTS-1:0] resp_ready_o;
    resp_beat_t [`CCU_NUM_PORTS-1:0] resp_beat_i;
    logic       [`CCU_NUM_PORTS-1:0] resp_valid_o;
    logic       [`CCU_NUM_PORTS-1:0] resp_ready_i;
    logic       [`CCU_NUM_PORTS-1:0] resp_ack_i;
    logic                            snoop_valid_i;
    logic                            snoop_ready_o;
    addr_t                           snoop_addr_i;
    logic                            snoop_valid_o;
    logic                            snoop_ready_i;
    logic                            snoop_clr_i;
    logic       [`CCU_NUM_PORTS-1:0] resp_hs;
    logic                            snoop_hs;

    line_addr_t                resp_q[`CCU_NUM_PORTS][$];  // outstanding bursts per port.
    line_addr_t                snoop_q[$];
    logic [`CCU_NUM_PORTS-1:0] in_burst;
    string                     cur_test;
    int unsigned               errors;
    int unsigned               errors_at_start;
    int unsigned               tests_ok;
    int unsigned               tests_bad;
    logic                      burst_done;

    ccu_conflict_manager i_ccu_conflict_manager (.*);

    assign resp_hs  = resp_valid_i & resp_ready_o;
    assign snoop_hs = snoop_valid_i & snoop_ready_o;

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired, the tests did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic line_addr_t line_of(addr_t a);
        return a[`CCU_LINE_BASE +: `CCU_LINE_WIDTH];
    endfunction

    function automatic addr_t addr_for(line_addr_t base, int unsigned off);
        addr_t a;
        a = addr_t'($urandom());  // bits outside the line are noise.
        a[`CCU_LINE_BASE +: `CCU_LINE_WIDTH] = line_addr_t'(base + off);
        return a;
    endfunction

    function automatic bit holds(line_addr_t q[$], line_addr_t l);
        foreach (q[i]) begin
            if (q[i] == l) return 1'b1;
        end
        return 1'b0;
    endfunction

    // reference model, checked and updated mid cycle.
    always @(negedge clk_i) begin
        if (rst_ni) begin
            for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
                assert (!(resp_valid_o[p] && holds(snoop_q, line_of(resp_beat_i[p].addr))))
                else begin
                    $display("mismatch %s: resp_valid_o[%0d] expected 0 actual 1", cur_test, p);
                    errors++;
                end
                assert (!(snoop_valid_o && holds(resp_q[p], line_of(snoop_addr_i))))
                else begin
                    $display("mismatch %s: snoop_valid_o expected 0 actual 1", cur_test);
                    errors++;
                end
            end
            for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
                if (resp_ack_i[p] && resp_q[p].size() > 0) void'(resp_q[p].pop_front());
                if (resp_valid_o[p] && resp_ready_i[p]) begin
                    if (!in_burst[p]) resp_q[p].push_back(line_of(resp_beat_i[p].addr));
                    in_burst[p] = !resp_beat_i[p].last;
                end
            end
            if (snoop_clr_i && snoop_q.size() > 0) void'(snoop_q.pop_front());
            if (snoop_valid_o && snoop_ready_i) snoop_q.push_back(line_of(snoop_addr_i));
        end
    end

    task automatic check_value(input string what, input logic expected, input logic actual);
        assert (expected == actual)
        else begin
            $display("mismatch %s %s: expected %0b actual %0b", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic offer_resp(input int p, input addr_t a, input logic last);
        @(posedge clk_i);
        resp_valid_i[p]     <= 1'b1;
        resp_beat_i[p].addr <= a;
        resp_beat_i[p].last <= last;
    endtask

    task automatic wait_resp(input int p);
        int unsigned n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!resp_hs[p] && n < wait_limit);
        if (!resp_hs[p]) begin
            $display("timeout in %s, response on port %0d was never accepted", cur_test, p);
            errors++;
        end
        @(posedge clk_i);
        resp_valid_i[p] <= 1'b0;
    endtask

    task automatic stall_resp_ready(input int p, input int unsigned cycles);
        @(posedge clk_i);
        resp_ready_i[p] <= 1'b0;
        repeat (cycles) @(posedge clk_i);
        resp_ready_i[p] <= 1'b1;
    endtask

    task automatic offer_snoop(input addr_t a);
        @(posedge clk_i);
        snoop_valid_i <= 1'b1;
        snoop_addr_i  <= a;
    endtask

    task automatic wait_snoop();
        int unsigned n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!snoop_hs && n < wait_limit);
        if (!snoop_hs) begin
            $display("timeout in %s, the snoop was never accepted", cur_test);
            errors++;
        end
        @(posedge clk_i);
        snoop_valid_i <= 1'b0;
    endtask

    task automatic pulse_ack(input int p);
        @(posedge clk_i);
        resp_ack_i[p] <= 1'b1;
        @(posedge clk_i);
        resp_ack_i[p] <= 1'b0;
    endtask

    task automatic pulse_clr();
        @(posedge clk_i);
        snoop_clr_i <= 1'b1;
        @(posedge clk_i);
        snoop_clr_i <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
        repeat ($urandom_range(1, 3)) @(posedge clk_i);
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            tests_ok++;
            $display("test %s done, ok", cur_test);
        end else begin
            tests_bad++;
            $display("test %s done, %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    initial begin
        line_addr_t  base;
        int unsigned beats;
        int unsigned total;
        void'($urandom(32'h5c54));
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        in_burst = '0;
        cur_test = "reset";
        rst_ni = 1'b0;
        resp_valid_i = '0;
        resp_beat_i = '0;
        resp_ready_i = '1;
        resp_ack_i = '0;
        snoop_valid_i = 1'b0;
        snoop_addr_i = '0;
        snoop_ready_i = 1'b1;
        snoop_clr_i = 1'b0;
        repeat (reset_cycles) @(posedge clk_i);
        rst_ni <= 1'b1;

        begin_test("pass_through");
        base = line_addr_t'($urandom());
        fork
            offer_resp(0, addr_for(base, 0), 1'b1);
            offer_snoop(addr_for(base, 1));
        join
        fork
            wait_resp(0);
            wait_snoop();
            begin
                @(negedge clk_i);  // both pass in the offer cycle.
                check_value("resp_valid_o[0]", 1'b1, resp_valid_o[0]);
                check_value("snoop_valid_o", 1'b1, snoop_valid_o);
            end
        join
        fork
            pulse_ack(0);
            pulse_clr();
        join
        end_test();

        begin_test("snoop_waits_for_ack");
        base = line_addr_t'($urandom());
        offer_resp(0, addr_for(base, 0), 1'b1);
        wait_resp(0);
        offer_snoop(addr_for(base, 0));
        repeat (4) begin
            @(negedge clk_i);
            check_value("snoop_valid_o", 1'b0, snoop_valid_o);
        end
        pulse_ack(0);
        wait_snoop();
        pulse_clr();
        end_test();

        begin_test("resp_waits_for_clear");
        base = line_addr_t'($urandom());
        offer_snoop(addr_for(base, 0));
        wait_snoop();
        offer_resp(1, addr_for(base, 0), 1'b1);
        repeat (4) begin
            @(negedge clk_i);
            check_value("resp_valid_o[1]", 1'b0, resp_valid_o[1]);
        end
        fork
            pulse_clr();
            stall_resp_ready(1, $urandom_range(2, 4));  // released output waits on ready.
        join
        wait_resp(1);
        pulse_ack(1);
        end_test();

        begin_test("same_line_both_ports");
        base = line_addr_t'($urandom());
        fork
            offer_snoop(addr_for(base, 0));
            offer_resp(0, addr_for(base, 0), 1'b1);
            offer_resp(1, addr_for(base, 0), 1'b1);
        join
        fork
            begin
                wait_snoop();
                pulse_clr();
            end
            begin
                wait_resp(0);
                pulse_ack(0);
            end
            begin
                wait_resp(1);
                pulse_ack(1);
            end
        join
        end_test();

        begin_test("fifo_full");
        base = line_addr_t'($urandom());
        for (int i = 0; i < `CCU_RESP_DEPTH; i++) begin
            offer_resp(0, addr_for(base, i), 1'b1);
            wait_resp(0);
        end
        @(negedge clk_i);
        check_value("resp_ready_o[0] when full", 1'b0, resp_ready_o[0]);
        pulse_ack(0);
        @(negedge clk_i);
        check_value("resp_ready_o[0] after one ack", 1'b1, resp_ready_o[0]);
        repeat (`CCU_RESP_DEPTH - 1) pulse_ack(0);
        for (int i = 0; i < `CCU_SNOOP_DEPTH; i++) begin
            offer_snoop(addr_for(base, 8 + i));
            wait_snoop();
        end
        @(negedge clk_i);
        check_value("snoop_ready_o when full", 1'b0, snoop_ready_o);
        pulse_clr();
        @(negedge clk_i);
        check_value("snoop_ready_o after one clear", 1'b1, snoop_ready_o);
        repeat (`CCU_SNOOP_DEPTH - 1) pulse_clr();
        end_test();

        begin_test("burst_lock");
        base = line_addr_t'($urandom());
        beats = $urandom_range(2, 4);
        burst_done = 1'b0;
        fork
            begin
                for (int b = 0; b < beats; b++) begin
                    if (b > 0) repeat ($urandom_range(0, 2)) @(posedge clk_i);
                    offer_resp(1, addr_for(base, 0), logic'(b == beats - 1));
                    wait_resp(1);
                end
                burst_done = 1'b1;
                pulse_ack(1);
            end
            begin
                repeat (3) @(posedge clk_i);  // after the first beat left.
                offer_snoop(addr_for(base, 0));
                wait_snoop();
                check_value("burst ended before snoop", 1'b1, burst_done);
                pulse_clr();
            end
        join
        end_test();

        total = errors + i_ccu_conflict_manager.i_conflict_chk.fail_count;
        $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, total);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ccu_conflict.f
+incdir+include
source/ccu_pkg.sv
source/addr_lookup_fifo.sv
source/resp_port_arbiter.sv
source/snoop_conflict_unit.sv
source/ccu_conflict_manager.sv
bench/ccu_conflict_chk.sv
bench/tb_ccu_conflict_manager.sv

//--- include/ccu_settings.svh
`ifndef CCU_SETTINGS_SVH
`define CCU_SETTINGS_SVH

// full address as seen on the snoop and response streams.
`define CCU_ADDR_WIDTH 32

// lowest line bit, 64 byte lines.
`define CCU_LINE_BASE 6

// compared slice of the address.
`define CCU_LINE_WIDTH 10

// response ports and outstanding entries per fifo.
`define CCU_NUM_PORTS 2
`define CCU_RESP_DEPTH 4
`define CCU_SNOOP_DEPTH 4

`endif

//--- source/addr_lookup_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module addr_lookup_fifo import ccu_pkg::*; #(
    parameter int unsigned depth        = 4,
    parameter int unsigned lookup_ports = 1
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              push_i,
    input  logic                              pop_i,
    input  line_addr_t                        data_i,
    output logic                              full_o,
    input  line_addr_t [lookup_ports-1:0]     lookup_i,
    output logic       [lookup_ports-1:0]     match_o
);

    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned cnt_w = $clog2(depth + 1);

    line_addr_t [depth-1:0] mem_q;
    logic       [depth-1:0] valid_q;
    logic       [ptr_w-1:0] wr_ptr_q;
    logic       [ptr_w-1:0] rd_ptr_q;
    logic       [cnt_w-1:0] count_q;
    logic                   do_push;
    logic                   do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == cnt_w'(depth));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && (count_q != '0);  // pop on empty is ignored.

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            valid_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q          <= next_ptr(wr_ptr_q);
                valid_q[wr_ptr_q] <= 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q          <= next_ptr(rd_ptr_q);
                valid_q[rd_ptr_q] <= 1'b0;
            end
            count_q <= count_q + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // every lookup port sees every live entry.
    always_comb begin
        match_o = '0;
        for (int unsigned p = 0; p < lookup_ports; p++) begin
            for (int unsigned e = 0; e < depth; e++) begin
                if (valid_q[e] && (mem_q[e] == lookup_i[p])) begin
                    match_o[p] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ccu_conflict_manager.sv
`timescale 1ns/100ps
`default_nettype none

`include "ccu_settings.svh"

module ccu_conflict_manager import ccu_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic       [`CCU_NUM_PORTS-1:0] resp_valid_i,
    output logic       [`CCU_NUM_PORTS-1:0] resp_ready_o,
    input  resp_beat_t [`CCU_NUM_PORTS-1:0] resp_beat_i,
    output logic       [`CCU_NUM_PORTS-1:0] resp_valid_o,
    input  logic       [`CCU_NUM_PORTS-1:0] resp_ready_i,
    input  logic       [`CCU_NUM_PORTS-1:0] resp_ack_i,
    input  logic                            snoop_valid_i,
    output logic                            snoop_ready_o,
    input  addr_t                           snoop_addr_i,
    output logic                            snoop_valid_o,
    input  logic                            snoop_ready_i,
    input  logic                            snoop_clr_i
);

    line_addr_t                snoop_line;
    line_vec_t                 resp_line;
    logic [`CCU_NUM_PORTS-1:0] fork_valid;
    logic [`CCU_NUM_PORTS-1:0] fork_ready;
    logic [`CCU_NUM_PORTS-1:0] arb_snoop_valid;
    logic [`CCU_NUM_PORTS-1:0] arb_snoop_ready;
    logic [`CCU_NUM_PORTS-1:0] hold_conflict;
    logic [`CCU_NUM_PORTS-1:0] resp_match;   // port fifo holds the snoop line.
    logic [`CCU_NUM_PORTS-1:0] snoop_match;  // snoop fifo holds the port line.

    assign snoop_line = snoop_addr_i[`CCU_LINE_BASE +: `CCU_LINE_WIDTH];

    for (genvar i = 0; i < `CCU_NUM_PORTS; i++) begin : gen_port
        assign resp_line[i] = resp_beat_i[i].addr[`CCU_LINE_BASE +: `CCU_LINE_WIDTH];

        resp_port_arbiter i_resp_port_arbiter (
            .clk_i,
            .rst_ni,
            .resp_valid_i      (resp_valid_i[i]),
            .resp_beat_i       (resp_beat_i[i]),
            .resp_ready_o      (resp_ready_o[i]),
            .resp_valid_o      (resp_valid_o[i]),
            .resp_ready_i      (resp_ready_i[i]),
            .resp_ack_i        (resp_ack_i[i]),
            .snoop_line_i      (snoop_line),
            .fork_valid_i      (fork_valid[i]),
            .fork_ready_o      (fork_ready[i]),
            .arb_snoop_valid_o (arb_snoop_valid[i]),
            .arb_snoop_ready_i (arb_snoop_ready[i]),
            .hold_conflict_i   (hold_conflict[i]),
            .snoop_hit_i       (snoop_match[i]),
            .resp_match_o      (resp_match[i])
        );
    end

    snoop_conflict_unit i_snoop_conflict_unit (
        .clk_i,
        .rst_ni,
        .snoop_valid_i,
        .snoop_line_i      (snoop_line),
        .snoop_ready_o,
        .snoop_valid_o,
        .snoop_ready_i,
        .snoop_clr_i,
        .resp_line_i       (resp_line),
        .resp_pending_i    (resp_valid_i),
        .fork_valid_o      (fork_valid),
        .fork_ready_i      (fork_ready),
        .hold_conflict_o   (hold_conflict),
        .arb_snoop_valid_i (arb_snoop_valid),
        .arb_snoop_ready_o (arb_snoop_ready),
        .resp_match_i      (resp_match),
        .snoop_hit_o       (snoop_match)
    );

endmodule

`default_nettype wire

//--- source/ccu_pkg.sv
`default_nettype none

`include "ccu_settings.svh"

package ccu_pkg;

    typedef logic [`CCU_ADDR_WIDTH-1:0] addr_t;

    // the part of an address that identifies a cache line.
    typedef logic [`CCU_LINE_WIDTH-1:0] line_addr_t;

    typedef struct packed {
        addr_t addr;
        logic  last;  // final beat of the burst.
    } resp_beat_t;

    // one line address per response port.
    typedef line_addr_t [`CCU_NUM_PORTS-1:0] line_vec_t;

endpackage

`default_nettype wire

//--- source/resp_port_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "ccu_settings.svh"

module resp_port_arbiter import ccu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       resp_valid_i,
    input  resp_beat_t resp_beat_i,
    output logic       resp_ready_o,
    output logic       resp_valid_o,
    input  logic       resp_ready_i,
    input  logic       resp_ack_i,
    input  line_addr_t snoop_line_i,
    input  logic       fork_valid_i,
    output logic       fork_ready_o,
    output logic       arb_snoop_valid_o,
    input  logic       arb_snoop_ready_i,
    input  logic       hold_conflict_i,
    input  logic       snoop_hit_i,
    output logic       resp_match_o
);

    line_addr_t resp_line;
    logic       fifo_full;
    logic       fifo_push;
    logic       resp_block;
    logic       req_resp;
    logic       req_snoop;
    logic       sel;           // 1 selects the snoop.
    logic       sel_q;
    logic       rr_q;
    logic       arb_lock_q;
    logic       arb_valid;
    logic       arb_ready;
    logic       resp_xfer;
    logic       burst_lock_q;

    assign resp_line = resp_beat_i.addr[`CCU_LINE_BASE +: `CCU_LINE_WIDTH];

    // a new burst waits on a full fifo; a running one does not.
    assign resp_block = (fifo_full && !burst_lock_q) || hold_conflict_i;
    assign req_resp   = resp_valid_i && !resp_block;
    assign req_snoop  = fork_valid_i && !burst_lock_q;  // no snoop inside a burst.

    always_comb begin
        if (arb_lock_q) begin
            sel = sel_q;
        end else if (req_resp && req_snoop) begin
            sel = rr_q;
        end else begin
            sel = req_snoop;
        end
    end

    assign arb_valid = sel ? req_snoop : req_resp;
    assign arb_ready = sel ? arb_snoop_ready_i : (resp_ready_i && !snoop_hit_i);

    // responses to a line with an outstanding snoop stay hidden.
    assign resp_valid_o      = arb_valid && !sel && !snoop_hit_i;
    assign resp_ready_o      = !sel && arb_ready && !resp_block;
    assign arb_snoop_valid_o = arb_valid && sel;
    assign fork_ready_o      = arb_snoop_valid_o && arb_snoop_ready_i;

    assign resp_xfer = resp_valid_o && resp_ready_i;
    assign fifo_push = resp_xfer && !burst_lock_q;  // first beat only.

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sel_q        <= 1'b0;
            rr_q         <= 1'b0;
            arb_lock_q   <= 1'b0;
            burst_lock_q <= 1'b0;
        end else begin
            arb_lock_q <= arb_valid && !arb_ready;
            if (arb_valid && !arb_ready) begin
                sel_q <= sel;
            end
            if (arb_valid && arb_ready) begin
                rr_q <= !sel;  // the other side goes first next time.
            end
            if (resp_xfer) begin
                burst_lock_q <= !resp_beat_i.last;
            end
        end
    end

    addr_lookup_fifo #(
        .depth        (`CCU_RESP_DEPTH),
        .lookup_ports (1)
    ) i_resp_fifo (
        .clk_i,
        .rst_ni,
        .push_i   (fifo_push),
        .pop_i    (resp_ack_i),
        .data_i   (resp_line),
        .full_o   (fifo_full),
        .lookup_i (snoop_line_i),
        .match_o  (resp_match_o)
    );

endmodule

`default_nettype wire

//--- source/snoop_conflict_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "ccu_settings.svh"

module snoop_conflict_unit import ccu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      snoop_valid_i,
    input  line_addr_t                snoop_line_i,
    output logic                      snoop_ready_o,
    output logic                      snoop_valid_o,
    input  logic                      snoop_ready_i,
    input  logic                      snoop_clr_i,
    input  line_vec_t                 resp_line_i,
    input  logic [`CCU_NUM_PORTS-1:0] resp_pending_i,
    output logic [`CCU_NUM_PORTS-1:0] fork_valid_o,
    input  logic [`CCU_NUM_PORTS-1:0] fork_ready_i,
    output logic [`CCU_NUM_PORTS-1:0] hold_conflict_o,
    input  logic [`CCU_NUM_PORTS-1:0] arb_snoop_valid_i,
    output logic [`CCU_NUM_PORTS-1:0] arb_snoop_ready_o,
    input  logic [`CCU_NUM_PORTS-1:0] resp_match_i,
    output logic [`CCU_NUM_PORTS-1:0] snoop_hit_o
);

    logic [`CCU_NUM_PORTS-1:0] addr_conflict;
    logic [`CCU_NUM_PORTS-1:0] sel;
    logic [`CCU_NUM_PORTS-1:0] sel_q;
    logic                      lock_q;
    logic                      fifo_full;
    logic                      snoop_valid_in;
    logic                      fork_active;
    logic                      fork_accept;
    logic                      joined;
    logic                      any_match;
    logic                      fire;

    // ports offering a response to the same line right now.
    always_comb begin
        for (int unsigned p = 0; p < `CCU_NUM_PORTS; p++) begin
            addr_conflict[p] = resp_pending_i[p] && (resp_line_i[p] == snoop_line_i);
        end
    end

    assign sel            = lock_q ? sel_q : addr_conflict;
    assign snoop_valid_in = snoop_valid_i && !fifo_full;

    // every conflicting port is granted by the same join transfer.
    assign fork_active  = lock_q || (snoop_valid_in && |addr_conflict);
    assign fork_valid_o = {`CCU_NUM_PORTS{fork_active}} & sel;
    assign fork_accept  = fork_active && &(~sel | fork_ready_i);

    // a late response to the same line waits behind the frozen snoop.
    assign hold_conflict_o = {`CCU_NUM_PORTS{lock_q}} & addr_conflict & ~sel_q;

    // join with the arbitrated ports, then filter on the response fifos.
    assign joined    = &(~sel | arb_snoop_valid_i);
    assign any_match = |resp_match_i;

    assign snoop_valid_o     = snoop_valid_in && joined && !any_match;
    assign snoop_ready_o     = !fifo_full && joined && !any_match && snoop_ready_i;
    assign fire              = snoop_valid_o && snoop_ready_i;
    assign arb_snoop_ready_o = {`CCU_NUM_PORTS{fire}} & sel;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lock_q <= 1'b0;
            sel_q  <= '0;
        end else begin
            if (!lock_q) begin
                if (fork_active && !fork_accept) begin
                    lock_q <= 1'b1;
                    sel_q  <= addr_conflict;  // freeze the selection.
                end
            end else if (fork_accept) begin
                lock_q <= 1'b0;
            end
        end
    end

    addr_lookup_fifo #(
        .depth        (`CCU_SNOOP_DEPTH),
        .lookup_ports (`CCU_NUM_PORTS)
    ) i_snoop_fifo (
        .clk_i,
        .rst_ni,
        .push_i   (fire),
        .pop_i    (snoop_clr_i),
        .data_i   (snoop_line_i),
        .full_o   (fifo_full),
        .lookup_i (resp_line_i),
        .match_o  (snoop_hit_o)
    );

endmodule

`default_nettype wire
